//--- logic/wb_pkg.sv
/* Writeback stage shared definitions
   Lane geometry, memory-op and writeback-kind encodings, stage structs */
package wb_pkg;

	localparam int NUM_LANES = 16;
	localparam int LANE_W = 32;
	localparam int VEC_W = NUM_LANES * LANE_W;
	localparam int BYTES_PER_LANE = LANE_W / 8;

	// Writes to this register redirect the program counter
	localparam int PC_REG = 31;

	// Encoding of instruction bits 28:25 for format C
	typedef enum logic [3:0]
	{
		MEM_B           = 4'd0,
		MEM_BX          = 4'd1,
		MEM_S           = 4'd2,
		MEM_SX          = 4'd3,
		MEM_L           = 4'd4,
		MEM_SYNC        = 4'd5,
		MEM_CONTROL_REG = 4'd6,
		MEM_BLOCK       = 4'd7,
		MEM_BLOCK_M     = 4'd8,
		MEM_BLOCK_IM    = 4'd9,
		MEM_STRIDED     = 4'd10,
		MEM_STRIDED_M   = 4'd11,
		MEM_STRIDED_IM  = 4'd12,
		MEM_GATHER      = 4'd13,
		MEM_GATHER_M    = 4'd14,
		MEM_GATHER_IM   = 4'd15
	} mem_op_e;

	// Where the register file value comes from
	typedef enum logic [2:0]
	{
		WB_ARITH,
		WB_SYNC_STORE,
		WB_SCALAR_LOAD,
		WB_BLOCK_LOAD,
		WB_LANE_LOAD
	} wb_kind_e;

	typedef struct packed
	{
		logic [31:0] instruction;
		logic [31:0] pc;
		logic [6:0] writeback_reg;
		logic writeback_is_vector;
		logic has_writeback;
		logic [NUM_LANES-1:0] mask;
		logic was_access;
		logic [VEC_W-1:0] result;	// effective address for loads
		logic [3:0] reg_lane_select;
		logic [3:0] cache_lane_select;
	} ma_stage_t;

	typedef struct packed
	{
		logic hit;
		logic load_collision;
		logic [VEC_W-1:0] data;
	} dcache_resp_t;

	typedef struct packed
	{
		logic has_writeback;
		logic writeback_is_vector;
		logic [6:0] writeback_reg;
		logic [VEC_W-1:0] writeback_value;
		logic [NUM_LANES-1:0] writeback_mask;
	} wb_result_t;

	typedef struct packed
	{
		logic request;
		logic [31:0] pc;
	} rollback_t;

endpackage

//--- logic/mem_op_decode.sv
/* Memory-op decode
   Splits out load flag, memory op and writeback source from the instruction */
`timescale 1ns/1ps

module mem_op_decode
(
	input logic [31:0] instruction,
	output wb_pkg::mem_op_e mem_op,
	output wb_pkg::wb_kind_e wb_kind,
	output logic is_load
);
	import wb_pkg::*;

	logic is_fmt_c;
	logic is_sync_store;

	// Format C is the memory-access format
	assign is_fmt_c = instruction[31:30] == 2'b10;
	assign is_load = is_fmt_c && instruction[29];
	assign mem_op = mem_op_e'(instruction[28:25]);

	// Store (bit 29 clear) of the synchronized kind returns a status value
	assign is_sync_store = instruction[31:25] == {2'b10, 1'b0, MEM_SYNC};

	always_comb
	begin
		if (is_sync_store)
		begin
			wb_kind = WB_SYNC_STORE;
		end
		else if (is_load && mem_op != MEM_CONTROL_REG)
		begin
			case (mem_op)
				MEM_BLOCK,
				MEM_BLOCK_M,
				MEM_BLOCK_IM:
					wb_kind = WB_BLOCK_LOAD;

				// One lane per access
				MEM_STRIDED,
				MEM_STRIDED_M,
				MEM_STRIDED_IM,
				MEM_GATHER,
				MEM_GATHER_M,
				MEM_GATHER_IM:
					wb_kind = WB_LANE_LOAD;

				default:
					wb_kind = WB_SCALAR_LOAD;
			endcase
		end
		else
		begin
			// Control register reads come back through the result too
			wb_kind = WB_ARITH;
		end
	end

endmodule

//--- logic/load_aligner.sv
/* Load aligner
   Extracts and extends sub-word loads, byte-swaps block lines per lane */
`timescale 1ns/1ps

module load_aligner
(
	input wb_pkg::ma_stage_t ma,
	input wb_pkg::mem_op_e mem_op,
	input logic [wb_pkg::VEC_W-1:0] cache_data,
	output logic [wb_pkg::LANE_W-1:0] aligned_word,
	output logic [wb_pkg::VEC_W-1:0] swapped_line
);
	import wb_pkg::*;

	logic [NUM_LANES-1:0][LANE_W-1:0] cache_lanes;
	logic [NUM_LANES-1:0][LANE_W-1:0] swapped_lanes;
	logic [3:0] lane_idx;
	logic [LANE_W-1:0] lane_value;
	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;

	assign cache_lanes = cache_data;

	// Cache numbers lanes from the top down
	assign lane_idx = 4'd15 - ma.cache_lane_select;
	assign lane_value = cache_lanes[lane_idx];

	// Address offset picks the byte, big-endian within the lane
	always_comb
	begin
		case (ma.result[1:0])
			2'b00: byte_aligned = lane_value[31:24];
			2'b01: byte_aligned = lane_value[23:16];
			2'b10: byte_aligned = lane_value[15:8];
			default: byte_aligned = lane_value[7:0];
		endcase
	end

	// Halfwords swapped into little-endian order
	always_comb
	begin
		if (ma.result[1])
			half_aligned = {lane_value[7:0], lane_value[15:8]};
		else
			half_aligned = {lane_value[23:16], lane_value[31:24]};
	end

	always_comb
	begin
		case (mem_op)
			MEM_B:
				aligned_word = {24'b0, byte_aligned};
			MEM_BX:
				aligned_word = {{24{byte_aligned[7]}}, byte_aligned};
			MEM_S:
				aligned_word = {16'b0, half_aligned};
			MEM_SX:
				aligned_word = {{16{half_aligned[15]}}, half_aligned};
			default:
				// Full word, and what strided/gather lanes use
				aligned_word = {lane_value[7:0], lane_value[15:8],
					lane_value[23:16], lane_value[31:24]};
		endcase
	end

	// Reverse byte order inside every lane
	for (genvar lane = 0; lane < NUM_LANES; lane++)
	begin : g_lane
		for (genvar b = 0; b < BYTES_PER_LANE; b++)
		begin : g_byte
			assign swapped_lanes[lane][b*8 +: 8] =
				cache_lanes[lane][(BYTES_PER_LANE-1-b)*8 +: 8];
		end
	end

	assign swapped_line = swapped_lanes;

endmodule

//--- logic/writeback_select.sv
/* Writeback select
   Rollback and suspend decisions, next register value and mask, output register */
`timescale 1ns/1ps

module writeback_select
(
	input logic clk,
	input logic reset,
	input wb_pkg::ma_stage_t ma,
	input wb_pkg::dcache_resp_t cache,
	input logic stbuf_rollback,
	input wb_pkg::wb_kind_e wb_kind,
	input logic is_load,
	input logic [wb_pkg::LANE_W-1:0] aligned_word,
	input logic [wb_pkg::VEC_W-1:0] swapped_line,
	output wb_pkg::wb_result_t wb,
	output wb_pkg::rollback_t rollback,
	output logic suspend_request
);
	import wb_pkg::*;

	logic cache_miss;
	logic load_to_pc;
	logic [VEC_W-1:0] value_nxt;
	logic [NUM_LANES-1:0] mask_nxt;

	assign cache_miss = is_load && ma.was_access && !cache.hit && !cache.load_collision;

	assign load_to_pc = is_load && ma.has_writeback && !ma.writeback_is_vector
		&& ma.writeback_reg == 7'(PC_REG);

	// Miss checked first so a missed load never jumps to garbage
	always_comb
	begin
		if (cache.load_collision || cache_miss || stbuf_rollback)
		begin
			rollback.request = 1'b1;
			rollback.pc = ma.pc - 32'd4;
		end
		else if (load_to_pc)
		begin
			rollback.request = 1'b1;
			rollback.pc = aligned_word;
		end
		else
		begin
			rollback.request = 1'b0;
			rollback.pc = '0;
		end
	end

	assign suspend_request = cache_miss || stbuf_rollback;

	always_comb
	begin
		case (wb_kind)
			WB_SYNC_STORE:
			begin
				// Store success flag comes back in the cache data
				value_nxt = cache.data;
				mask_nxt = '1;
			end
			WB_SCALAR_LOAD:
			begin
				value_nxt = {NUM_LANES{aligned_word}};
				mask_nxt = '1;
			end
			WB_BLOCK_LOAD:
			begin
				value_nxt = swapped_line;
				mask_nxt = ma.mask;
			end
			WB_LANE_LOAD:
			begin
				value_nxt = {NUM_LANES{aligned_word}};
				mask_nxt = ({{(NUM_LANES-1){1'b0}}, 1'b1} << ma.reg_lane_select) & ma.mask;
			end
			default:
			begin
				value_nxt = ma.result;
				mask_nxt = ma.mask;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			wb <= '0;
		else
		begin
			wb.has_writeback <= ma.has_writeback && !rollback.request;
			wb.writeback_is_vector <= ma.writeback_is_vector;
			wb.writeback_reg <= ma.writeback_reg;
			wb.writeback_value <= value_nxt;
			wb.writeback_mask <= mask_nxt;
		end
	end

endmodule

//--- logic/writeback_stage.sv
/* Vector pipeline writeback stage
   Decode, load alignment and writeback selection toward the register file */
`timescale 1ns/1ps

module writeback_stage
(
	input logic clk,
	input logic reset,
	input wb_pkg::ma_stage_t ma,
	input wb_pkg::dcache_resp_t cache,
	input logic stbuf_rollback,
	output wb_pkg::wb_result_t wb,
	output wb_pkg::rollback_t rollback,
	output logic suspend_request
);
	import wb_pkg::*;

	mem_op_e mem_op;
	wb_kind_e wb_kind;
	logic is_load;
	logic [LANE_W-1:0] aligned_word;
	logic [VEC_W-1:0] swapped_line;

	mem_op_decode decode
	(
		.instruction(ma.instruction),
		.mem_op(mem_op),
		.wb_kind(wb_kind),
		.is_load(is_load)
	);

	load_aligner aligner
	(
		.ma(ma),
		.mem_op(mem_op),
		.cache_data(cache.data),
		.aligned_word(aligned_word),
		.swapped_line(swapped_line)
	);

	writeback_select select
	(
		.clk(clk),
		.reset(reset),
		.ma(ma),
		.cache(cache),
		.stbuf_rollback(stbuf_rollback),
		.wb_kind(wb_kind),
		.is_load(is_load),
		.aligned_word(aligned_word),
		.swapped_line(swapped_line),
		.wb(wb),
		.rollback(rollback),
		.suspend_request(suspend_request)
	);

endmodule

//--- bench/writeback_stage_assert.sv
/* Writeback stage checker
   Reference rules for rollback, suspend and the registered writeback */
`timescale 1ns/1ps

module writeback_stage_assert
(
	input logic clk,
	input logic reset,
	input wb_pkg::ma_stage_t ma,
	input wb_pkg::dcache_resp_t cache,
	input logic stbuf_rollback,
	input wb_pkg::wb_result_t wb,
	input wb_pkg::rollback_t rollback,
	input logic suspend_request
);
	import wb_pkg::*;

	int error_count = 0;
	mem_op_e op;
	logic load;
	logic miss;
	logic stall;
	logic pc_load;
	logic [1:0] offset;
	logic [VEC_W-1:0] reversed;
	logic [LANE_W-1:0] le_word;
	logic [LANE_W-1:0] exp_word;
	wb_result_t exp_wb;

	task automatic record_failure(input string what);
		error_count = error_count + 1;
		$error("error %0t: %s", $time, what);
	endtask

	assign op = mem_op_e'(ma.instruction[28:25]);
	assign load = ma.instruction[31:29] == 3'b101;
	assign miss = load && ma.was_access && !cache.hit && !cache.load_collision;
	assign stall = miss || cache.load_collision || stbuf_rollback;
	assign pc_load = load && ma.has_writeback && !ma.writeback_is_vector
		&& ma.writeback_reg == 7'(PC_REG);

	// Full byte reversal moves cache lane 15-n to lane n, little-endian
	assign reversed = {<<8{cache.data}};
	assign le_word = reversed[LANE_W*ma.cache_lane_select +: LANE_W];
	assign offset = ma.result[1:0];

	always_comb
	begin
		case (op)
			MEM_B: exp_word = 32'(le_word[8*offset +: 8]);
			MEM_BX: exp_word = 32'(signed'(le_word[8*offset +: 8]));
			MEM_S: exp_word = 32'(le_word[16*offset[1] +: 16]);
			MEM_SX: exp_word = 32'(signed'(le_word[16*offset[1] +: 16]));
			default: exp_word = le_word;
		endcase
	end

	always_comb
	begin
		exp_wb.has_writeback = ma.has_writeback && !stall && !pc_load;
		exp_wb.writeback_is_vector = ma.writeback_is_vector;
		exp_wb.writeback_reg = ma.writeback_reg;
		exp_wb.writeback_value = {NUM_LANES{exp_word}};
		exp_wb.writeback_mask = '1;
		if (ma.instruction[31:25] == 7'b1000101)
			exp_wb.writeback_value = cache.data;
		else if (!load || op == MEM_CONTROL_REG)
		begin
			exp_wb.writeback_value = ma.result;
			exp_wb.writeback_mask = ma.mask;
		end
		else if (op >= MEM_STRIDED)
			exp_wb.writeback_mask = ma.mask & (16'd1 << ma.reg_lane_select);
		else if (op >= MEM_BLOCK)
		begin
			// Lane order restored, bytes stay reversed per lane
			exp_wb.writeback_value = {<<32{reversed}};
			exp_wb.writeback_mask = ma.mask;
		end
	end

	a_reset: assert property (@(posedge clk) $past(reset) |-> wb == '0)
		else record_failure("wb not cleared by reset");
	a_writeback: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> wb == $past(exp_wb))
		else record_failure("registered writeback differs from expected");
	a_stall: assert property (@(posedge clk) disable iff (reset)
		stall |-> rollback.request && rollback.pc == ma.pc - 32'd4)
		else record_failure("no rollback to pc minus 4");
	a_suspend: assert property (@(posedge clk) disable iff (reset)
		suspend_request == (miss || stbuf_rollback))
		else record_failure("suspend_request wrong");
	a_pc_load: assert property (@(posedge clk) disable iff (reset)
		!stall && pc_load |-> rollback.request && rollback.pc == exp_word)
		else record_failure("load to pc did not redirect to loaded word");
	a_quiet: assert property (@(posedge clk) disable iff (reset)
		!stall && !pc_load |-> !rollback.request)
		else record_failure("unexpected rollback");

endmodule

bind writeback_stage writeback_stage_assert checks (.*);

//--- bench/writeback_stage_tb.sv
/* Writeback stage testbench
   LFSR-driven phases over every memory op, checked by the bound assertions */
`timescale 1ns/1ps

module writeback_stage_tb;
	import wb_pkg::*;

	localparam int PHASE_CYCLES = 40;
	localparam int NUM_PHASES = 18;
	localparam int TIMEOUT_CYCLES = NUM_PHASES * PHASE_CYCLES + 100;

	logic clk;
	logic reset;
	ma_stage_t ma;
	dcache_resp_t cache;
	logic stbuf_rollback;
	wb_result_t wb;
	rollback_t rollback;
	logic suspend_request;
	logic [31:0] lfsr = 32'd72987;
	int cycles = 0;

	writeback_stage UUT
	(
		.clk(clk),
		.reset(reset),
		.ma(ma),
		.cache(cache),
		.stbuf_rollback(stbuf_rollback),
		.wb(wb),
		.rollback(rollback),
		.suspend_request(suspend_request)
	);

	// Galois LFSR, one step per bit
	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < width; i++)
		begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hD0000001 : lfsr >> 1;
		end
		return bits;
	endfunction

	function automatic logic [VEC_W-1:0] random_line();
		logic [VEC_W-1:0] line;
		for (int i = 0; i < NUM_LANES; i++)
			line[i*LANE_W +: LANE_W] = random_bits(LANE_W);
		return line;
	endfunction

	// Disturbed cycles may miss, collide or hit a store buffer rollback
	task automatic drive_op(input logic [6:0] opcode, input logic disturb);
		@(posedge clk);
		ma.instruction <= {opcode, 25'(random_bits(25))};
		ma.pc <= random_bits(32);
		ma.writeback_reg <= (random_bits(2) == 0) ? 7'd31 : 7'(random_bits(7));
		ma.writeback_is_vector <= random_bits(1) != 0;
		ma.has_writeback <= random_bits(2) != 0;
		ma.mask <= 16'(random_bits(16));
		ma.was_access <= random_bits(3) != 0;
		ma.result <= random_line();
		ma.reg_lane_select <= 4'(random_bits(4));
		ma.cache_lane_select <= 4'(random_bits(4));
		cache.data <= random_line();
		cache.hit <= !disturb || random_bits(1) != 0;
		cache.load_collision <= disturb && random_bits(3) == 0;
		stbuf_rollback <= disturb && random_bits(3) == 0;
	endtask

	task automatic run_phase(input logic [6:0] opcode);
		for (int i = 0; i < PHASE_CYCLES; i++)
			drive_op(opcode, i >= PHASE_CYCLES / 2);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
		begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Testbench failed");
			$fatal(1, "timeout");
		end
	end

	always @(negedge clk)
	begin
		if (UUT.checks.error_count != 0)
		begin
			$display("A checker assertion failed before time %0t", $time);
			$display("Testbench failed");
			$fatal(1, "stopping at the first failed check");
		end
	end

	initial
	begin
		reset = 1'b1;
		ma = '0;
		cache = '0;
		stbuf_rollback = 1'b0;
		// Live traffic while reset is held
		for (int i = 0; i < 5; i++)
			drive_op(7'b0000000, 1'b0);
		reset <= 1'b0;
		run_phase(7'b0000000);
		// Synchronized store
		run_phase(7'b1000101);
		for (int op = 0; op <= int'(MEM_GATHER_IM); op++)
			run_phase({3'b101, 4'(op)});
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (UUT.checks.error_count == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
		begin
			$display("Testbench failed");
			$fatal(1, "checker reported failures");
		end
	end

endmodule

//--- sim.f
logic/wb_pkg.sv
logic/mem_op_decode.sv
logic/load_aligner.sv
logic/writeback_select.sv
logic/writeback_stage.sv
bench/writeback_stage_assert.sv
bench/writeback_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = writeback_stage_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)
RUN_ARGS = +verilator+error+limit+100
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
